//--- list.f
rtl/ds_pkg.sv
rtl/ds_stage_ctrl.sv
rtl/ds_decoder.sv
rtl/ds_gpr_file.sv
rtl/ds_bypass.sv
rtl/ds_branch_unit.sv
rtl/ds_id_stage.sv
test/tb_clock_gen.sv
test/tb_id_stage_sva.sv
test/tb_id_stage.sv

//--- rtl/ds_branch_unit.sv
// Branch resolution

`timescale 1ns/10ps

module ds_branch_unit (
  input  logic              i_ds_valid,
  input  logic              i_bren,
  input  ds_pkg::br_func_t  i_br_func,
  input  ds_pkg::gpr_data_t i_rs1_data,
  input  ds_pkg::gpr_data_t i_rs2_data,
  input  ds_pkg::pc_t       i_pc,
  input  ds_pkg::imm_t      i_imm,
  input  logic              i_load_stall,
  output logic              o_br_taken,
  output ds_pkg::pc_t       o_br_target,
  output logic              o_br_stall
);

  import ds_pkg::*;

  logic cond;

  always_comb begin
    case (i_br_func)
      BR_EQ:   cond = (i_rs1_data == i_rs2_data);
      BR_NE:   cond = (i_rs1_data != i_rs2_data);
      BR_LT:   cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      BR_GE:   cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      default: cond = 1'b0;
    endcase
  end

  assign o_br_taken  = i_ds_valid && i_bren && cond;
  assign o_br_target = i_pc + i_imm;
  assign o_br_stall  = o_br_taken && i_load_stall; // operands not ready yet, fetch must hold

endmodule

//--- rtl/ds_bypass.sv
// Operand forwarding muxes

`timescale 1ns/10ps

module ds_bypass (
  input  ds_pkg::gpr_addr_t i_rs1,
  input  ds_pkg::gpr_addr_t i_rs2,
  input  ds_pkg::gpr_data_t i_rf_data1,
  input  ds_pkg::gpr_data_t i_rf_data2,
  input  ds_pkg::gpr_addr_t i_es_rd,
  input  ds_pkg::gpr_addr_t i_ms_rd,
  input  ds_pkg::gpr_addr_t i_ws_rd,
  input  ds_pkg::gpr_data_t i_es_result,
  input  ds_pkg::gpr_data_t i_ms_result,
  input  ds_pkg::gpr_data_t i_ws_result,
  output ds_pkg::gpr_data_t o_rs1_data,
  output ds_pkg::gpr_data_t o_rs2_data
);

  import ds_pkg::*;

  // youngest matching stage wins, rd of zero never forwards
  function automatic gpr_data_t fwd_sel(input gpr_addr_t rs, input gpr_data_t rf_data,
                                        input gpr_addr_t es_rd, input gpr_data_t es_res,
                                        input gpr_addr_t ms_rd, input gpr_data_t ms_res,
                                        input gpr_addr_t ws_rd, input gpr_data_t ws_res);
    if (es_rd != '0 && rs == es_rd) return es_res;
    else if (ms_rd != '0 && rs == ms_rd) return ms_res;
    else if (ws_rd != '0 && rs == ws_rd) return ws_res;
    else return rf_data;
  endfunction

  assign o_rs1_data = fwd_sel(i_rs1, i_rf_data1, i_es_rd, i_es_result,
                              i_ms_rd, i_ms_result, i_ws_rd, i_ws_result);
  assign o_rs2_data = fwd_sel(i_rs2, i_rf_data2, i_es_rd, i_es_result,
                              i_ms_rd, i_ms_result, i_ws_rd, i_ws_result);

endmodule

//--- rtl/ds_decoder.sv
// RV64I subset decoder

`timescale 1ns/10ps

module ds_decoder (
  input  ds_pkg::inst_t     i_inst,
  output ds_pkg::gpr_addr_t o_rs1,
  output ds_pkg::gpr_addr_t o_rs2,
  output ds_pkg::gpr_addr_t o_rd,
  output ds_pkg::imm_t      o_imm,
  output ds_pkg::alu_op_t   o_alu_op,
  output logic              o_alu_src2_imm,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output ds_pkg::mem_op_t   o_mem_op,
  output logic              o_bren,
  output ds_pkg::br_func_t  o_br_func,
  output logic              o_invalid
);

  import ds_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // raw fields, whatever the format
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};

  assign o_mem_op  = funct3;
  assign o_br_func = funct3;

  always_comb begin
    o_imm          = '0;
    o_alu_op       = ALU_NONE;
    o_alu_src2_imm = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_bren         = 1'b0;
    o_invalid      = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin // addi
        if (funct3 == F3_ADD) begin
          o_imm          = imm_i;
          o_alu_op       = ALU_ADD;
          o_alu_src2_imm = 1'b1;
          o_gpr_wen      = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_OP: begin // add / sub
        if (funct3 == F3_ADD && funct7 == F7_BASE) begin
          o_alu_op  = ALU_ADD;
          o_gpr_wen = 1'b1;
        end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
          o_alu_op  = ALU_SUB;
          o_gpr_wen = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == F3_DWORD) begin
          o_imm          = imm_i;
          o_alu_op       = ALU_ADD; // address calc
          o_alu_src2_imm = 1'b1;
          o_gpr_wen      = 1'b1;
          o_mem_ren      = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_DWORD) begin
          o_imm          = imm_s;
          o_alu_op       = ALU_ADD;
          o_alu_src2_imm = 1'b1;
          o_mem_wen      = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == BR_EQ || funct3 == BR_NE || funct3 == BR_LT || funct3 == BR_GE) begin
          o_imm  = imm_b;
          o_bren = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      default: o_invalid = 1'b1;
    endcase
  end

endmodule

//--- rtl/ds_gpr_file.sv
// General register file

`timescale 1ns/10ps

module ds_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  ds_pkg::gpr_addr_t i_raddr1,
  input  ds_pkg::gpr_addr_t i_raddr2,
  output ds_pkg::gpr_data_t o_rdata1,
  output ds_pkg::gpr_data_t o_rdata2,
  input  logic              i_wen,
  input  ds_pkg::gpr_addr_t i_waddr,
  input  ds_pkg::gpr_data_t i_wdata
);

  import ds_pkg::*;

  gpr_data_t regs [1:GPR_NUM-1]; // x0 not stored

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- rtl/ds_id_stage.sv
// Decode stage top

`timescale 1ns/10ps

module ds_id_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // fetch handshake
  input  logic              i_fs_valid,
  input  ds_pkg::inst_t     i_fs_inst,
  input  ds_pkg::pc_t       i_fs_pc,
  output logic              o_ds_allowin,
  // execute handshake
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  // forwarding
  input  logic              i_es_load_sel,
  input  ds_pkg::gpr_addr_t i_es_rd,
  input  ds_pkg::gpr_data_t i_es_result,
  input  ds_pkg::gpr_addr_t i_ms_rd,
  input  ds_pkg::gpr_data_t i_ms_result,
  input  ds_pkg::gpr_addr_t i_ws_fw_rd,
  input  ds_pkg::gpr_data_t i_ws_fw_result,
  // register write port
  input  logic              i_ws_wen,
  input  ds_pkg::gpr_addr_t i_ws_waddr,
  input  ds_pkg::gpr_data_t i_ws_wdata,
  // to fetch
  output logic              o_br_taken,
  output ds_pkg::pc_t       o_br_target,
  output logic              o_br_stall,
  // to execute
  output ds_pkg::pc_t       o_ds_pc,
  output ds_pkg::gpr_data_t o_ds_rs1_data,
  output ds_pkg::gpr_data_t o_ds_rs2_data,
  output ds_pkg::imm_t      o_ds_imm,
  output ds_pkg::gpr_addr_t o_ds_rd,
  output ds_pkg::alu_op_t   o_ds_alu_op,
  output logic              o_ds_alu_src2_imm,
  output logic              o_ds_gpr_wen,
  output logic              o_ds_mem_ren,
  output logic              o_ds_mem_wen,
  output ds_pkg::mem_op_t   o_ds_mem_op,
  output logic              o_ds_invalid
);

  import ds_pkg::*;

  logic      ds_valid;
  inst_t     ds_inst;
  logic      load_stall;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  gpr_data_t rf_data1;
  gpr_data_t rf_data2;
  logic      bren;
  br_func_t  br_func;

  ds_stage_ctrl u_ctrl (
    .i_clk            (i_clk           ),
    .i_rst_n          (i_rst_n         ),
    .i_fs_valid       (i_fs_valid      ),
    .i_fs_inst        (i_fs_inst       ),
    .i_fs_pc          (i_fs_pc         ),
    .i_es_allowin     (i_es_allowin    ),
    .i_es_load_sel    (i_es_load_sel   ),
    .i_es_rd          (i_es_rd         ),
    .i_rs1            (rs1             ),
    .i_rs2            (rs2             ),
    .o_ds_valid       (ds_valid        ),
    .o_ds_inst        (ds_inst         ),
    .o_ds_pc          (o_ds_pc         ),
    .o_load_stall     (load_stall      ),
    .o_ds_allowin     (o_ds_allowin    ),
    .o_ds_to_es_valid (o_ds_to_es_valid)
  );

  ds_decoder u_dec (
    .i_inst         (ds_inst          ),
    .o_rs1          (rs1              ),
    .o_rs2          (rs2              ),
    .o_rd           (o_ds_rd          ),
    .o_imm          (o_ds_imm         ),
    .o_alu_op       (o_ds_alu_op      ),
    .o_alu_src2_imm (o_ds_alu_src2_imm),
    .o_gpr_wen      (o_ds_gpr_wen     ),
    .o_mem_ren      (o_ds_mem_ren     ),
    .o_mem_wen      (o_ds_mem_wen     ),
    .o_mem_op       (o_ds_mem_op      ),
    .o_bren         (bren             ),
    .o_br_func      (br_func          ),
    .o_invalid      (o_ds_invalid     )
  );

  ds_gpr_file u_gprs (
    .i_clk    (i_clk     ),
    .i_rst_n  (i_rst_n   ),
    .i_raddr1 (rs1       ),
    .i_raddr2 (rs2       ),
    .o_rdata1 (rf_data1  ),
    .o_rdata2 (rf_data2  ),
    .i_wen    (i_ws_wen  ),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata)
  );

  ds_bypass u_bypass (
    .i_rs1       (rs1           ),
    .i_rs2       (rs2           ),
    .i_rf_data1  (rf_data1      ),
    .i_rf_data2  (rf_data2      ),
    .i_es_rd     (i_es_rd       ),
    .i_ms_rd     (i_ms_rd       ),
    .i_ws_rd     (i_ws_fw_rd    ),
    .i_es_result (i_es_result   ),
    .i_ms_result (i_ms_result   ),
    .i_ws_result (i_ws_fw_result),
    .o_rs1_data  (o_ds_rs1_data ),
    .o_rs2_data  (o_ds_rs2_data )
  );

  ds_branch_unit u_bru (
    .i_ds_valid   (ds_valid     ),
    .i_bren       (bren         ),
    .i_br_func    (br_func      ),
    .i_rs1_data   (o_ds_rs1_data),
    .i_rs2_data   (o_ds_rs2_data),
    .i_pc         (o_ds_pc      ),
    .i_imm        (o_ds_imm     ),
    .i_load_stall (load_stall   ),
    .o_br_taken   (o_br_taken   ),
    .o_br_target  (o_br_target  ),
    .o_br_stall   (o_br_stall   )
  );

endmodule

//--- rtl/ds_pkg.sv
// Decode stage shared definitions

package ds_pkg;

  localparam int XLEN       = 64;
  localparam int INST_WD    = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int GPR_NUM    = 32;
  localparam int INST_BYTES = 4; // pc increment

  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [XLEN-1:0]        pc_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [XLEN-1:0]        gpr_data_t;
  typedef logic [XLEN-1:0]        imm_t;
  typedef logic [3:0]             alu_op_t;
  typedef logic [2:0]             mem_op_t;  // funct3 of load/store
  typedef logic [2:0]             br_func_t; // funct3 of branch

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 / funct7 codes of the kept subset
  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_DWORD = 3'b011; // ld / sd
  localparam logic [6:0] F7_BASE  = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;

  localparam br_func_t BR_EQ = 3'b000;
  localparam br_func_t BR_NE = 3'b001;
  localparam br_func_t BR_LT = 3'b100;
  localparam br_func_t BR_GE = 3'b101;

  // alu operations
  localparam alu_op_t ALU_NONE = 4'd0;
  localparam alu_op_t ALU_ADD  = 4'd1;
  localparam alu_op_t ALU_SUB  = 4'd2;

endpackage

//--- rtl/ds_stage_ctrl.sv
// Decode stage register and handshake

`timescale 1ns/10ps

module ds_stage_ctrl (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // from fetch
  input  logic              i_fs_valid,
  input  ds_pkg::inst_t     i_fs_inst,
  input  ds_pkg::pc_t       i_fs_pc,
  // from execute
  input  logic              i_es_allowin,
  input  logic              i_es_load_sel,
  input  ds_pkg::gpr_addr_t i_es_rd,
  // decoded source fields of the held instruction
  input  ds_pkg::gpr_addr_t i_rs1,
  input  ds_pkg::gpr_addr_t i_rs2,
  output logic              o_ds_valid,
  output ds_pkg::inst_t     o_ds_inst,
  output ds_pkg::pc_t       o_ds_pc,
  output logic              o_load_stall,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid
);

  logic ds_ready_go;

  // load in execute feeds a source of this instruction, wait for it to reach memory
  assign o_load_stall = i_es_load_sel && (i_es_rd != '0) &&
                        ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

  assign ds_ready_go      = ~o_load_stall;
  assign o_ds_allowin     = !o_ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = o_ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      o_ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_ds_inst <= i_fs_inst;
      o_ds_pc   <= i_fs_pc;
    end
  end

endmodule

//--- run.sh
#!/bin/bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -f list.f --top-module tb_id_stage -o tb_sim > build.log 2>&1 ||
{ cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "run incomplete"; exit 1; }
echo "run passed"

//--- test/tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/10ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD = 5; // 10 ns clock
  localparam int RST_CYCLES  = 10;

  initial o_clk = 1'b0;
  always #HALF_PERIOD o_clk = ~o_clk;

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

//--- test/tb_id_stage.sv
// Decode stage testbench

`timescale 1ns/10ps

module tb_id_stage;

  import ds_pkg::*;

  localparam int N_INST      = 2000;
  localparam int WATCHDOG_NS = N_INST * 40 * 10;

  logic clk;
  logic rst_n;

  logic      i_fs_valid;
  inst_t     i_fs_inst;
  pc_t       i_fs_pc;
  logic      i_es_allowin;
  logic      i_es_load_sel;
  gpr_addr_t i_es_rd;
  gpr_data_t i_es_result;
  gpr_addr_t i_ms_rd;
  gpr_data_t i_ms_result;
  gpr_addr_t i_ws_fw_rd;
  gpr_data_t i_ws_fw_result;
  logic      i_ws_wen;
  gpr_addr_t i_ws_waddr;
  gpr_data_t i_ws_wdata;

  logic      o_ds_allowin;
  logic      o_ds_to_es_valid;
  logic      o_br_taken;
  pc_t       o_br_target;
  logic      o_br_stall;
  pc_t       o_ds_pc;
  gpr_data_t o_ds_rs1_data;
  gpr_data_t o_ds_rs2_data;
  imm_t      o_ds_imm;
  gpr_addr_t o_ds_rd;
  alu_op_t   o_ds_alu_op;
  logic      o_ds_alu_src2_imm;
  logic      o_ds_gpr_wen;
  logic      o_ds_mem_ren;
  logic      o_ds_mem_wen;
  mem_op_t   o_ds_mem_op;
  logic      o_ds_invalid;

  // model state
  logic        m_valid;
  inst_t       m_inst;
  pc_t         m_pc;
  gpr_data_t   shadow [0:GPR_NUM-1];
  logic        exp_allowin;
  int          accepted;
  int          delivered;
  int          stall_cycles;
  logic [31:0] lcg_state = 32'd37950;

  tb_clock_gen u_clk_gen (
    .o_clk   (clk  ),
    .o_rst_n (rst_n)
  );

  ds_id_stage dut (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_fs_valid (i_fs_valid), .i_fs_inst (i_fs_inst), .i_fs_pc (i_fs_pc),
    .o_ds_allowin (o_ds_allowin), .i_es_allowin (i_es_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .i_es_load_sel (i_es_load_sel), .i_es_rd (i_es_rd), .i_es_result (i_es_result),
    .i_ms_rd (i_ms_rd), .i_ms_result (i_ms_result),
    .i_ws_fw_rd (i_ws_fw_rd), .i_ws_fw_result (i_ws_fw_result),
    .i_ws_wen (i_ws_wen), .i_ws_waddr (i_ws_waddr), .i_ws_wdata (i_ws_wdata),
    .o_br_taken (o_br_taken), .o_br_target (o_br_target), .o_br_stall (o_br_stall),
    .o_ds_pc (o_ds_pc), .o_ds_rs1_data (o_ds_rs1_data), .o_ds_rs2_data (o_ds_rs2_data),
    .o_ds_imm (o_ds_imm), .o_ds_rd (o_ds_rd), .o_ds_alu_op (o_ds_alu_op),
    .o_ds_alu_src2_imm (o_ds_alu_src2_imm), .o_ds_gpr_wen (o_ds_gpr_wen),
    .o_ds_mem_ren (o_ds_mem_ren), .o_ds_mem_wen (o_ds_mem_wen),
    .o_ds_mem_op (o_ds_mem_op), .o_ds_invalid (o_ds_invalid)
  );

  // upper halves of two LCG steps, low bits are weak
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic logic chance(input int unsigned pct);
    return (next_rand() % 100) < pct;
  endfunction

  function automatic gpr_addr_t small_reg();
    logic [31:0] r;
    r = next_rand();
    return r[31] ? r[4:0] : {2'b00, r[2:0]}; // mostly x0..x7 to provoke hazards
  endfunction

  function automatic gpr_data_t rand_value();
    logic [31:0] a;
    logic [31:0] b;
    a = next_rand();
    b = next_rand();
    if (a[7]) return {60'b0, b[3:0]}; // small values so beq/bne hit both ways
    return {a, b};
  endfunction

  function automatic inst_t make_inst();
    inst_t       inst;
    logic [31:0] r;
    int unsigned kind;
    logic [31:0] k;
    inst = next_rand();
    r    = next_rand();
    if ((r % 100) >= 80) return inst;
    inst[19:15] = small_reg();
    inst[24:20] = small_reg();
    inst[11:7]  = small_reg();
    kind = (r >> 8) % 9;
    k    = kind - 5;
    case (kind)
      0: begin
        inst[6:0] = OPC_OP_IMM;
        inst[14:12] = 3'b000;
      end
      1, 2: begin
        inst[6:0] = OPC_OP;
        inst[14:12] = 3'b000;
        inst[31:25] = (kind == 2) ? 7'b0100000 : 7'b0000000;
      end
      3: begin
        inst[6:0] = OPC_LOAD;
        inst[14:12] = 3'b011;
      end
      4: begin
        inst[6:0] = OPC_STORE;
        inst[14:12] = 3'b011;
      end
      default: begin
        inst[6:0] = OPC_BRANCH;
        inst[14:12] = {k[1], 1'b0, k[0]}; // beq, bne, blt, bge
      end
    endcase
    return inst;
  endfunction

  // expected control: {alu_op, mem_op, src2_imm, gpr_wen, mem_ren, mem_wen, invalid}
  task automatic model_decode(input inst_t inst, output imm_t imm,
                              output logic [11:0] ctrl, output logic bren);
    logic [2:0] f3;
    logic [6:0] f7;
    alu_op_t    op;
    logic       src2;
    logic       wen;
    logic       ren;
    logic       swen;
    logic       inv;
    f3   = inst[14:12];
    f7   = inst[31:25];
    imm  = '0;
    op   = ALU_NONE;
    src2 = 1'b0;
    wen  = 1'b0;
    ren  = 1'b0;
    swen = 1'b0;
    bren = 1'b0;
    inv  = 1'b1;
    if (inst[6:0] == OPC_OP_IMM && f3 == 3'b000) begin
      imm = 64'($signed(inst[31:20]));
      {op, src2, wen, inv} = {ALU_ADD, 3'b110};
    end else if (inst[6:0] == OPC_OP && f3 == 3'b000 && f7 == 7'b0000000) begin
      {op, wen, inv} = {ALU_ADD, 2'b10};
    end else if (inst[6:0] == OPC_OP && f3 == 3'b000 && f7 == 7'b0100000) begin
      {op, wen, inv} = {ALU_SUB, 2'b10};
    end else if (inst[6:0] == OPC_LOAD && f3 == 3'b011) begin
      imm = 64'($signed(inst[31:20]));
      {op, src2, wen, ren, inv} = {ALU_ADD, 4'b1110};
    end else if (inst[6:0] == OPC_STORE && f3 == 3'b011) begin
      imm = 64'($signed({inst[31:25], inst[11:7]}));
      {op, src2, swen, inv} = {ALU_ADD, 3'b110};
    end else if (inst[6:0] == OPC_BRANCH && f3[1] == 1'b0) begin
      imm  = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
      bren = 1'b1;
      inv  = 1'b0;
    end
    ctrl = {op, f3, src2, wen, ren, swen, inv};
  endtask

  // oldest source first, so a younger match overrides it
  function automatic gpr_data_t model_operand(input gpr_addr_t idx);
    gpr_data_t v;
    if (idx == '0) return '0;
    v = shadow[idx];
    if (i_ws_fw_rd == idx) v = i_ws_fw_result;
    if (i_ms_rd == idx) v = i_ms_result;
    if (i_es_rd == idx) v = i_es_result;
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_data(input string name, input gpr_data_t act, input gpr_data_t exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_pc(input string name, input pc_t act, input pc_t exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_addr(input string name, input gpr_addr_t act, input gpr_addr_t exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_ctrl(input string name, input logic [11:0] act,
                            input logic [11:0] exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_outputs();
    gpr_addr_t   rs1;
    gpr_addr_t   rs2;
    logic        stall;
    imm_t        e_imm;
    logic [11:0] e_ctrl;
    logic        e_bren;
    gpr_data_t   op1;
    gpr_data_t   op2;
    logic        cond;
    logic        e_taken;
    rs1   = m_inst[19:15];
    rs2   = m_inst[24:20];
    stall = m_valid && i_es_load_sel && (i_es_rd != '0) && (i_es_rd == rs1 || i_es_rd == rs2);
    exp_allowin = !m_valid || (!stall && i_es_allowin);
    e_taken = 1'b0;
    check_ctrl("to_es_valid,allowin", {10'b0, o_ds_to_es_valid, o_ds_allowin},
               {10'b0, m_valid && !stall, exp_allowin});
    if (m_valid) begin
      model_decode(m_inst, e_imm, e_ctrl, e_bren);
      op1 = model_operand(rs1);
      op2 = model_operand(rs2);
      check_pc("o_ds_pc", o_ds_pc, m_pc);
      check_addr("o_ds_rd", o_ds_rd, m_inst[11:7]);
      check_data("o_ds_imm", o_ds_imm, e_imm);
      check_ctrl("alu_op,mem_op,src2,wen,ren,swen,inv",
                 {o_ds_alu_op, o_ds_mem_op, o_ds_alu_src2_imm, o_ds_gpr_wen,
                  o_ds_mem_ren, o_ds_mem_wen, o_ds_invalid}, e_ctrl);
      check_data("o_ds_rs1_data", o_ds_rs1_data, op1);
      check_data("o_ds_rs2_data", o_ds_rs2_data, op2);
      case (m_inst[14:12])
        3'b000:  cond = (op1 == op2);
        3'b001:  cond = (op1 != op2);
        3'b100:  cond = ($signed(op1) < $signed(op2));
        default: cond = !($signed(op1) < $signed(op2));
      endcase
      e_taken = e_bren && cond;
      check_pc("o_br_target", o_br_target, m_pc + e_imm);
      if (!stall && i_es_allowin) delivered++;
      if (stall) stall_cycles++;
    end
    check_ctrl("br_taken,br_stall", {10'b0, o_br_taken, o_br_stall},
               {10'b0, e_taken, e_taken && stall});
  endtask

  // inputs still hold the values seen at the edge
  task automatic update_model();
    if (i_ws_wen && i_ws_waddr != '0) shadow[i_ws_waddr] = i_ws_wdata;
    if (exp_allowin) begin
      m_valid = i_fs_valid;
      if (i_fs_valid) begin
        m_inst = i_fs_inst;
        m_pc   = i_fs_pc;
        accepted++;
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] t;
    t = next_rand();
    i_fs_valid     = chance(75);
    i_fs_inst      = make_inst();
    i_fs_pc        = {next_rand(), t[31:2], 2'b00};
    i_es_allowin   = chance(75);
    i_es_load_sel  = chance(20);
    i_es_rd        = small_reg();
    i_es_result    = rand_value();
    i_ms_rd        = small_reg();
    i_ms_result    = rand_value();
    i_ws_fw_rd     = small_reg();
    i_ws_fw_result = rand_value();
    i_ws_wen       = chance(50);
    i_ws_waddr     = small_reg();
    i_ws_wdata     = rand_value();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run timed out with %0d of %0d instructions accepted", accepted, N_INST);
    abort_run("timeout");
  end

  initial begin
    {i_fs_valid, i_es_allowin, i_es_load_sel, i_ws_wen} = '0;
    {i_fs_inst, i_fs_pc} = '0;
    {i_es_rd, i_ms_rd, i_ws_fw_rd, i_ws_waddr} = '0;
    {i_es_result, i_ms_result, i_ws_fw_result, i_ws_wdata} = '0;
    m_valid      = 1'b0;
    exp_allowin  = 1'b1;
    accepted     = 0;
    delivered    = 0;
    stall_cycles = 0;
    for (int i = 0; i < GPR_NUM; i++) shadow[i] = '0;
    @(posedge rst_n);
    while (accepted < N_INST) begin
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      #1;
      update_model();
      drive_inputs();
    end
    $display("accepted %0d, delivered %0d, stall cycles %0d", accepted, delivered, stall_cycles);
    if (dut.u_sva.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("ERROR: %0d assertion failures", dut.u_sva.fail_cnt);
      abort_run("assertion failures");
    end
  end

endmodule

//--- test/tb_id_stage_sva.sv
// Decode stage protocol assertions

`timescale 1ns/10ps

module tb_id_stage_sva (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_es_allowin,
  input logic              i_es_load_sel,
  input ds_pkg::gpr_addr_t i_es_rd,
  input logic              i_ds_to_es_valid,
  input ds_pkg::inst_t     i_ds_inst,
  input ds_pkg::pc_t       i_ds_pc,
  input logic              i_br_taken,
  input logic              i_br_stall
);

  int unsigned fail_cnt = 0; // failed assertions so far
  logic        use_hazard;

  // load in execute targets a raw source field of the held instruction
  assign use_hazard = i_es_load_sel && (i_es_rd != '0) &&
                      ((i_es_rd == i_ds_inst[19:15]) || (i_es_rd == i_ds_inst[24:20]));

  a_idle_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_ds_to_es_valid)
    else begin
      $error("output valid high right after reset");
      fail_cnt++;
    end

  // blocked by execute, the held instruction must not change
  a_hold_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_to_es_valid && !i_es_allowin) |=> (i_ds_pc == $past(i_ds_pc)))
    else begin
      $error("pc changed under back-pressure");
      fail_cnt++;
    end

  a_stall_needs_taken: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_stall |-> (i_br_taken && use_hazard))
    else begin
      $error("branch stall without taken branch and load-use hazard");
      fail_cnt++;
    end

  a_no_valid_in_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    use_hazard |-> !i_ds_to_es_valid)
    else begin
      $error("output valid during load-use stall");
      fail_cnt++;
    end

endmodule

bind ds_id_stage tb_id_stage_sva u_sva (
  .i_clk            (i_clk           ),
  .i_rst_n          (i_rst_n         ),
  .i_es_allowin     (i_es_allowin    ),
  .i_es_load_sel    (i_es_load_sel   ),
  .i_es_rd          (i_es_rd         ),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_inst        (ds_inst         ),
  .i_ds_pc          (o_ds_pc         ),
  .i_br_taken       (o_br_taken      ),
  .i_br_stall       (o_br_stall      )
);
